/* source/mask_alu_pkg.sv */
package mask_alu_pkg;

  localparam logic [2:0] opmvv = 3'b010;

  // funct6 codes under opmvv
  localparam logic [5:0] vmandn    = 6'b011000;
  localparam logic [5:0] vmand     = 6'b011001;
  localparam logic [5:0] vmor      = 6'b011010;
  localparam logic [5:0] vmxor     = 6'b011011;
  localparam logic [5:0] vmorn     = 6'b011100;
  localparam logic [5:0] vmnand    = 6'b011101;
  localparam logic [5:0] vmnor     = 6'b011110;
  localparam logic [5:0] vmxnor    = 6'b011111;
  localparam logic [5:0] vwxunary0 = 6'b010000;
  localparam logic [5:0] vmunary0  = 6'b010100;

  // vs1 field under vwxunary0
  localparam logic [4:0] vcpop  = 5'b10000;
  localparam logic [4:0] vfirst = 5'b10001;

  // vs1 field under vmunary0
  localparam logic [4:0] vmsbf = 5'b00001;
  localparam logic [4:0] vmsof = 5'b00010;
  localparam logic [4:0] vmsif = 5'b00011;
  localparam logic [4:0] viota = 5'b10000;
  localparam logic [4:0] vid   = 5'b10001;

  typedef enum logic [3:0] {
    op_none,
    op_vmandn, op_vmand, op_vmor, op_vmxor,
    op_vmorn, op_vmnand, op_vmnor, op_vmxnor,
    op_vcpop, op_vfirst,
    op_vmsbf, op_vmsif, op_vmsof,
    op_viota, op_vid
  } mask_op_e;

  typedef enum logic [1:0] {
    eew8  = 2'd0,
    eew16 = 2'd1,
    eew32 = 2'd2
  } eew_e;

  // log2 of the element width in bits
  function automatic int eew_log2(eew_e eew);
    case (eew)
      eew8:    return 3;
      eew16:   return 4;
      default: return 5;
    endcase
  endfunction

  function automatic int eew_bits(eew_e eew);
    return 1 << eew_log2(eew);
  endfunction

endpackage

/* source/mask_src_if.sv */
`timescale 1ns/1ns

interface mask_src_if #(
  parameter int vlen = 128
);

  mask_alu_pkg::mask_op_e     op;
  logic [vlen-1:0]            src2;
  logic [vlen-1:0]            src1;
  logic [vlen-1:0]            vd;
  logic [vlen-1:0]            v0;
  // bit j set when j < vl
  logic [vlen-1:0]            tail;
  logic                       vm;
  logic [$clog2(vlen)-1:0]    vstart;
  mask_alu_pkg::eew_e         vd_eew;
  logic [2:0]                 uop_index;

  modport prep (
    output op, src2, src1, vd, v0, tail, vm, vstart, vd_eew, uop_index
  );

  modport unit (
    input op, src2, src1, vd, v0, tail, vm, vstart, vd_eew, uop_index
  );

endinterface

/* source/mask_operand_prep.sv */
`timescale 1ns/1ns

module mask_operand_prep #(
  parameter int vlen = 128
) (
  input  logic                       uop_valid,
  input  logic [2:0]                 funct3,
  input  logic [5:0]                 funct6,
  input  logic [4:0]                 vs1,
  input  logic                       vm,
  input  logic [$clog2(vlen):0]      vl,
  input  logic [$clog2(vlen)-1:0]    vstart,
  input  mask_alu_pkg::eew_e         vd_eew,
  input  logic [2:0]                 uop_index,
  input  logic [vlen-1:0]            vs2_data,
  input  logic [vlen-1:0]            vs1_data,
  input  logic [vlen-1:0]            vd_data,
  input  logic [vlen-1:0]            v0_data,
  mask_src_if.prep                   src
);

  mask_alu_pkg::mask_op_e op;
  logic [vlen-1:0]        tail;
  logic [vlen-1:0]        active;

  always_comb begin
    op = mask_alu_pkg::op_none;
    if (uop_valid && funct3 == mask_alu_pkg::opmvv) begin
      case (funct6)
        mask_alu_pkg::vmandn: op = mask_alu_pkg::op_vmandn;
        mask_alu_pkg::vmand:  op = mask_alu_pkg::op_vmand;
        mask_alu_pkg::vmor:   op = mask_alu_pkg::op_vmor;
        mask_alu_pkg::vmxor:  op = mask_alu_pkg::op_vmxor;
        mask_alu_pkg::vmorn:  op = mask_alu_pkg::op_vmorn;
        mask_alu_pkg::vmnand: op = mask_alu_pkg::op_vmnand;
        mask_alu_pkg::vmnor:  op = mask_alu_pkg::op_vmnor;
        mask_alu_pkg::vmxnor: op = mask_alu_pkg::op_vmxnor;
        mask_alu_pkg::vwxunary0: begin
          case (vs1)
            mask_alu_pkg::vcpop:  op = mask_alu_pkg::op_vcpop;
            mask_alu_pkg::vfirst: op = mask_alu_pkg::op_vfirst;
            default:              op = mask_alu_pkg::op_none;
          endcase
        end
        mask_alu_pkg::vmunary0: begin
          case (vs1)
            mask_alu_pkg::vmsbf: op = mask_alu_pkg::op_vmsbf;
            mask_alu_pkg::vmsif: op = mask_alu_pkg::op_vmsif;
            mask_alu_pkg::vmsof: op = mask_alu_pkg::op_vmsof;
            mask_alu_pkg::viota: op = mask_alu_pkg::op_viota;
            mask_alu_pkg::vid:   op = mask_alu_pkg::op_vid;
            default:             op = mask_alu_pkg::op_none;
          endcase
        end
        default: op = mask_alu_pkg::op_none;
      endcase
    end
  end

  always_comb begin
    for (int j = 0; j < vlen; j++) begin
      tail[j] = (j < vl);
    end
  end

  // elements enabled by v0 when masked
  assign active = vm ? {vlen{1'b1}} : v0_data;

  always_comb begin
    case (op)
      mask_alu_pkg::op_vcpop,
      mask_alu_pkg::op_vfirst,
      mask_alu_pkg::op_vmsbf,
      mask_alu_pkg::op_vmsif,
      mask_alu_pkg::op_vmsof: src.src2 = vs2_data & tail & active;
      mask_alu_pkg::op_viota: src.src2 = vs2_data & active;
      // vid counts like viota over an all-ones source
      mask_alu_pkg::op_vid:   src.src2 = active;
      default:                src.src2 = vs2_data;
    endcase
  end

  assign src.op        = op;
  assign src.src1      = vs1_data;
  assign src.vd        = vd_data;
  assign src.v0        = v0_data;
  assign src.tail      = tail;
  assign src.vm        = vm;
  assign src.vstart    = vstart;
  assign src.vd_eew    = vd_eew;
  assign src.uop_index = uop_index;

  always_comb begin
    assert final (!uop_valid || vl <= vlen)
      else $error("vl %0d exceeds vlen %0d", vl, vlen);
  end

endmodule

/* source/mask_logic_unit.sv */
`timescale 1ns/1ns

module mask_logic_unit #(
  parameter int vlen = 128
) (
  mask_src_if.unit          src,
  output logic [vlen-1:0]   logic_result
);

  logic [vlen-1:0] bitwise;
  logic [vlen-1:0] prestart;

  // src2 is the left operand
  always_comb begin
    case (src.op)
      mask_alu_pkg::op_vmandn: bitwise = src.src2 & ~src.src1;
      mask_alu_pkg::op_vmand:  bitwise = src.src2 & src.src1;
      mask_alu_pkg::op_vmor:   bitwise = src.src2 | src.src1;
      mask_alu_pkg::op_vmxor:  bitwise = src.src2 ^ src.src1;
      mask_alu_pkg::op_vmorn:  bitwise = src.src2 | ~src.src1;
      mask_alu_pkg::op_vmnand: bitwise = ~(src.src2 & src.src1);
      mask_alu_pkg::op_vmnor:  bitwise = ~(src.src2 | src.src1);
      mask_alu_pkg::op_vmxnor: bitwise = ~(src.src2 ^ src.src1);
      default:                 bitwise = '0;
    endcase
  end

  always_comb begin
    for (int j = 0; j < vlen; j++) begin
      prestart[j] = (j < src.vstart);
    end
  end

  // elements below vstart keep the old destination
  assign logic_result = (prestart & src.vd) | (~prestart & bitwise);

endmodule

/* source/mask_scan_unit.sv */
`timescale 1ns/1ns

module mask_scan_unit #(
  parameter int vlen = 128
) (
  mask_src_if.unit          src,
  output logic [vlen-1:0]   scan_result
);

  localparam int idx_w = $clog2(vlen);

  logic              src_zero;
  logic [vlen-1:0]   first_one;
  logic [vlen-1:0]   sbf;
  logic [vlen-1:0]   sif;
  logic [vlen-1:0]   sof;
  logic [vlen-1:0]   keep_vd;
  logic [idx_w-1:0]  first_idx;
  logic [vlen-1:0]   vfirst_word;

  assign src_zero  = (src.src2 == '0);
  // isolate lowest set bit
  assign first_one = src.src2 & (~src.src2 + 1'b1);

  assign sof = src_zero ? {vlen{1'b1}} : first_one;
  assign sbf = src_zero ? {vlen{1'b1}} : first_one - 1'b1;
  assign sif = src_zero ? {vlen{1'b1}} : first_one | (first_one - 1'b1);

  always_comb begin
    first_idx = '0;
    for (int i = vlen - 1; i >= 0; i--) begin
      if (src.src2[i]) begin
        first_idx = idx_w'(i);
      end
    end
  end

  assign vfirst_word = src_zero ? {vlen{1'b1}} : {{(vlen - idx_w){1'b0}}, first_idx};

  // body elements masked off by v0
  assign keep_vd = src.vm ? '0 : (src.tail & ~src.v0);

  always_comb begin
    case (src.op)
      mask_alu_pkg::op_vfirst: scan_result = vfirst_word;
      mask_alu_pkg::op_vmsbf:  scan_result = (keep_vd & src.vd) | (~keep_vd & sbf);
      mask_alu_pkg::op_vmsif:  scan_result = (keep_vd & src.vd) | (~keep_vd & sif);
      mask_alu_pkg::op_vmsof:  scan_result = (keep_vd & src.vd) | (~keep_vd & sof);
      default:                 scan_result = '0;
    endcase
  end

endmodule

/* source/mask_count_unit.sv */
`timescale 1ns/1ns

module mask_count_unit #(
  parameter int vlen = 128
) (
  mask_src_if.unit          src,
  output logic [vlen-1:0]   count_result
);

  localparam int idx_w = $clog2(vlen);

  logic [idx_w-1:0]  prefix [vlen];
  logic [idx_w:0]    pop;
  logic [vlen-1:0]   iota_word;

  // prefix[i] counts set bits strictly below i
  always_comb begin
    prefix[0] = '0;
    for (int i = 1; i < vlen; i++) begin
      prefix[i] = prefix[i-1] + idx_w'(src.src2[i-1]);
    end
  end

  assign pop = {1'b0, prefix[vlen-1]} + (idx_w + 1)'(src.src2[vlen-1]);

  // pack the slice for this uop into vd_eew elements
  always_comb begin
    int sh;
    int base;
    int elem;
    int k;
    sh = mask_alu_pkg::eew_log2(src.vd_eew);
    base = int'(src.uop_index) * (vlen >> sh);
    iota_word = '0;
    for (int b = 0; b < vlen; b++) begin
      elem = base + (b >> sh);
      k = b & ((1 << sh) - 1);
      if (elem < vlen && k < idx_w) begin
        iota_word[b] = prefix[elem][k];
      end
    end
  end

  always_comb begin
    case (src.op)
      mask_alu_pkg::op_vcpop: count_result = {{(vlen - idx_w - 1){1'b0}}, pop};
      mask_alu_pkg::op_viota,
      mask_alu_pkg::op_vid:   count_result = iota_word;
      default:                count_result = '0;
    endcase
  end

  always_comb begin
    assert final (!(src.op == mask_alu_pkg::op_viota || src.op == mask_alu_pkg::op_vid) ||
                  src.vd_eew inside {mask_alu_pkg::eew8, mask_alu_pkg::eew16,
                                     mask_alu_pkg::eew32})
      else $error("vd_eew %0d is not a legal element width", src.vd_eew);
  end

endmodule

/* source/mask_alu_top.sv */
`timescale 1ns/1ns

module mask_alu_top #(
  parameter int vlen = 128
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       uop_valid,
  input  logic [2:0]                 funct3,
  input  logic [5:0]                 funct6,
  input  logic [4:0]                 vs1,
  input  logic                       vm,
  input  logic [$clog2(vlen):0]      vl,
  input  logic [$clog2(vlen)-1:0]    vstart,
  input  mask_alu_pkg::eew_e         vd_eew,
  input  logic [2:0]                 uop_index,
  input  logic [vlen-1:0]            vs2_data,
  input  logic [vlen-1:0]            vs1_data,
  input  logic [vlen-1:0]            vd_data,
  input  logic [vlen-1:0]            v0_data,
  output logic                       result_valid,
  output logic [vlen-1:0]            result_data
);

  logic [vlen-1:0] logic_result;
  logic [vlen-1:0] scan_result;
  logic [vlen-1:0] count_result;
  logic [vlen-1:0] sel_data;

  mask_src_if #(.vlen(vlen)) src ();

  mask_operand_prep #(.vlen(vlen)) u_prep (
    .uop_valid (uop_valid),
    .funct3    (funct3),
    .funct6    (funct6),
    .vs1       (vs1),
    .vm        (vm),
    .vl        (vl),
    .vstart    (vstart),
    .vd_eew    (vd_eew),
    .uop_index (uop_index),
    .vs2_data  (vs2_data),
    .vs1_data  (vs1_data),
    .vd_data   (vd_data),
    .v0_data   (v0_data),
    .src       (src)
  );

  mask_logic_unit #(.vlen(vlen)) u_logic (
    .src          (src),
    .logic_result (logic_result)
  );

  mask_scan_unit #(.vlen(vlen)) u_scan (
    .src         (src),
    .scan_result (scan_result)
  );

  mask_count_unit #(.vlen(vlen)) u_count (
    .src          (src),
    .count_result (count_result)
  );

  always_comb begin
    case (src.op)
      mask_alu_pkg::op_vcpop,
      mask_alu_pkg::op_viota,
      mask_alu_pkg::op_vid:    sel_data = count_result;
      mask_alu_pkg::op_vfirst,
      mask_alu_pkg::op_vmsbf,
      mask_alu_pkg::op_vmsif,
      mask_alu_pkg::op_vmsof:  sel_data = scan_result;
      mask_alu_pkg::op_none:   sel_data = '0;
      default:                 sel_data = logic_result;
    endcase
  end

  // result register with one cycle of latency
  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
      result_data  <= '0;
    end else begin
      result_valid <= (src.op != mask_alu_pkg::op_none);
      if (src.op != mask_alu_pkg::op_none) begin
        result_data <= sel_data;
      end
    end
  end

  assert property (@(posedge clk) disable iff (reset) !$isunknown(result_valid))
    else $error("result_valid is unknown");

endmodule

/* tests/mask_alu_checker.sv */
`timescale 1ns/1ns

module mask_alu_checker #(
  parameter int vlen = 128
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      uop_valid,
  input  logic [2:0]                funct3,
  input  logic [5:0]                funct6,
  input  logic [4:0]                vs1,
  input  logic                      vm,
  input  logic [$clog2(vlen):0]     vl,
  input  logic [$clog2(vlen)-1:0]   vstart,
  input  mask_alu_pkg::eew_e        vd_eew,
  input  logic [2:0]                uop_index,
  input  logic [vlen-1:0]           vs2_data,
  input  logic [vlen-1:0]           vs1_data,
  input  logic [vlen-1:0]           vd_data,
  input  logic [vlen-1:0]           v0_data,
  input  logic                      result_valid,
  input  logic [vlen-1:0]           result_data,
  output logic                      pending,
  output int                        error_count,
  output int                        check_count
);

  logic                   primed;
  logic                   exp_valid;
  logic                   data_due;
  logic [vlen-1:0]        exp_data;
  mask_alu_pkg::mask_op_e cur_op;

  function automatic mask_alu_pkg::mask_op_e decode_op();
    if (!uop_valid || funct3 != mask_alu_pkg::opmvv) return mask_alu_pkg::op_none;
    case (funct6)
      mask_alu_pkg::vmandn: return mask_alu_pkg::op_vmandn;
      mask_alu_pkg::vmand:  return mask_alu_pkg::op_vmand;
      mask_alu_pkg::vmor:   return mask_alu_pkg::op_vmor;
      mask_alu_pkg::vmxor:  return mask_alu_pkg::op_vmxor;
      mask_alu_pkg::vmorn:  return mask_alu_pkg::op_vmorn;
      mask_alu_pkg::vmnand: return mask_alu_pkg::op_vmnand;
      mask_alu_pkg::vmnor:  return mask_alu_pkg::op_vmnor;
      mask_alu_pkg::vmxnor: return mask_alu_pkg::op_vmxnor;
      mask_alu_pkg::vwxunary0: begin
        if (vs1 == mask_alu_pkg::vcpop) return mask_alu_pkg::op_vcpop;
        if (vs1 == mask_alu_pkg::vfirst) return mask_alu_pkg::op_vfirst;
      end
      mask_alu_pkg::vmunary0: begin
        if (vs1 == mask_alu_pkg::vmsbf) return mask_alu_pkg::op_vmsbf;
        if (vs1 == mask_alu_pkg::vmsif) return mask_alu_pkg::op_vmsif;
        if (vs1 == mask_alu_pkg::vmsof) return mask_alu_pkg::op_vmsof;
        if (vs1 == mask_alu_pkg::viota) return mask_alu_pkg::op_viota;
        if (vs1 == mask_alu_pkg::vid) return mask_alu_pkg::op_vid;
      end
      default: ;
    endcase
    return mask_alu_pkg::op_none;
  endfunction

  function automatic logic [vlen-1:0] model_word(mask_alu_pkg::mask_op_e op);
    logic [vlen-1:0] w;
    logic [vlen-1:0] s;
    int first;
    int cnt;
    int eb;
    int base;
    w = '0;
    first = -1;
    cnt = 0;
    // active source bits
    // the tail applies to every op but viota and vid
    for (int j = 0; j < vlen; j++) begin
      s[j] = (op == mask_alu_pkg::op_vid) || vs2_data[j];
      s[j] = s[j] && (vm || v0_data[j]);
      if (op != mask_alu_pkg::op_vid && op != mask_alu_pkg::op_viota) s[j] = s[j] && (j < vl);
      if (s[j] && first < 0) first = j;
      if (s[j]) cnt++;
    end
    case (op)
      mask_alu_pkg::op_vmandn: w = vs2_data & ~vs1_data;
      mask_alu_pkg::op_vmand:  w = vs2_data & vs1_data;
      mask_alu_pkg::op_vmor:   w = vs2_data | vs1_data;
      mask_alu_pkg::op_vmxor:  w = vs2_data ^ vs1_data;
      mask_alu_pkg::op_vmorn:  w = vs2_data | ~vs1_data;
      mask_alu_pkg::op_vmnand: w = ~(vs2_data & vs1_data);
      mask_alu_pkg::op_vmnor:  w = ~(vs2_data | vs1_data);
      mask_alu_pkg::op_vmxnor: w = ~(vs2_data ^ vs1_data);
      mask_alu_pkg::op_vcpop:  w = vlen'(cnt);
      mask_alu_pkg::op_vfirst: w = (first < 0) ? '1 : vlen'(first);
      mask_alu_pkg::op_vmsbf, mask_alu_pkg::op_vmsif, mask_alu_pkg::op_vmsof: begin
        for (int j = 0; j < vlen; j++) begin
          if (first < 0) w[j] = 1'b1;
          else if (op == mask_alu_pkg::op_vmsbf) w[j] = (j < first);
          else if (op == mask_alu_pkg::op_vmsif) w[j] = (j <= first);
          else w[j] = (j == first);
          if (!vm && j < vl && !v0_data[j]) w[j] = vd_data[j];
        end
      end
      mask_alu_pkg::op_viota, mask_alu_pkg::op_vid: begin
        eb = 8 << int'(vd_eew);
        base = int'(uop_index) * (vlen / eb);
        for (int i = 0; i < vlen / eb; i++) begin
          cnt = 0;
          for (int j = 0; j < base + i; j++) begin
            if (s[j]) cnt++;
          end
          for (int k = 0; k < eb; k++) begin
            w[i * eb + k] = cnt[k];
          end
        end
      end
      default: ;
    endcase
    // logical ops keep vd below vstart
    if (op >= mask_alu_pkg::op_vmandn && op <= mask_alu_pkg::op_vmxnor) begin
      for (int j = 0; j < vlen; j++) begin
        if (j < vstart) w[j] = vd_data[j];
      end
    end
    return w;
  endfunction

  initial begin
    primed = 1'b0;
    exp_valid = 1'b0;
    data_due = 1'b0;
    exp_data = '0;
    error_count = 0;
    check_count = 0;
  end

  // compare last cycle's prediction and then predict from the stable inputs
  always @(negedge clk) begin
    if (primed) begin
      check_count++;
      if (result_valid !== exp_valid) begin
        error_count++;
        $display("error at %0t ns: result_valid expected %b got %b",
                 $time, exp_valid, result_valid);
      end else if (data_due && result_data !== exp_data) begin
        error_count++;
        $display("error at %0t ns: result_data expected %h got %h",
                 $time, exp_data, result_data);
      end
    end
    cur_op = decode_op();
    exp_valid = !reset && cur_op != mask_alu_pkg::op_none;
    data_due = reset || exp_valid;
    exp_data = reset ? '0 : model_word(cur_op);
    primed = 1'b1;
  end

  assign pending = exp_valid;

endmodule

/* tests/tb_mask_alu.sv */
`timescale 1ns/1ns

module tb_mask_alu;

  localparam int vlen = 128;
  localparam int idx_w = $clog2(vlen);
  localparam int num_ops = 3000;
  localparam int drain_limit = 10;

  logic                   clk;
  logic                   reset;
  logic                   uop_valid;
  logic [2:0]             funct3;
  logic [5:0]             funct6;
  logic [4:0]             vs1;
  logic                   vm;
  logic [idx_w:0]         vl;
  logic [idx_w-1:0]       vstart;
  mask_alu_pkg::eew_e     vd_eew;
  logic [2:0]             uop_index;
  logic [vlen-1:0]        vs2_data;
  logic [vlen-1:0]        vs1_data;
  logic [vlen-1:0]        vd_data;
  logic [vlen-1:0]        v0_data;
  logic                   result_valid;
  logic [vlen-1:0]        result_data;
  logic                   pending;
  int                     error_count;
  int                     check_count;
  logic [31:0]            lfsr;

  // funct6 and vs1 of every kept instruction
  logic [5:0] f6_table [15] = '{
    mask_alu_pkg::vmandn, mask_alu_pkg::vmand, mask_alu_pkg::vmor, mask_alu_pkg::vmxor,
    mask_alu_pkg::vmorn, mask_alu_pkg::vmnand, mask_alu_pkg::vmnor, mask_alu_pkg::vmxnor,
    mask_alu_pkg::vwxunary0, mask_alu_pkg::vwxunary0,
    mask_alu_pkg::vmunary0, mask_alu_pkg::vmunary0, mask_alu_pkg::vmunary0,
    mask_alu_pkg::vmunary0, mask_alu_pkg::vmunary0
  };
  logic [4:0] vs1_table [15] = '{
    5'd0, 5'd0, 5'd0, 5'd0, 5'd0, 5'd0, 5'd0, 5'd0,
    mask_alu_pkg::vcpop, mask_alu_pkg::vfirst,
    mask_alu_pkg::vmsbf, mask_alu_pkg::vmsif, mask_alu_pkg::vmsof,
    mask_alu_pkg::viota, mask_alu_pkg::vid
  };

  mask_alu_top #(.vlen(vlen)) uut (
    .clk (clk), .reset (reset), .uop_valid (uop_valid),
    .funct3 (funct3), .funct6 (funct6), .vs1 (vs1), .vm (vm), .vl (vl),
    .vstart (vstart), .vd_eew (vd_eew), .uop_index (uop_index),
    .vs2_data (vs2_data), .vs1_data (vs1_data), .vd_data (vd_data), .v0_data (v0_data),
    .result_valid (result_valid), .result_data (result_data)
  );

  mask_alu_checker #(.vlen(vlen)) u_checker (
    .clk (clk), .reset (reset), .uop_valid (uop_valid),
    .funct3 (funct3), .funct6 (funct6), .vs1 (vs1), .vm (vm), .vl (vl),
    .vstart (vstart), .vd_eew (vd_eew), .uop_index (uop_index),
    .vs2_data (vs2_data), .vs1_data (vs1_data), .vd_data (vd_data), .v0_data (v0_data),
    .result_valid (result_valid), .result_data (result_data),
    .pending (pending), .error_count (error_count), .check_count (check_count)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // right-shift galois form with taps 32 30 26 25
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  task automatic draw(input int n, output logic [vlen-1:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic clear_inputs();
    uop_valid = 1'b0;
    funct3 = '0;
    funct6 = '0;
    vs1 = '0;
    vm = 1'b1;
    vl = '0;
    vstart = '0;
    vd_eew = mask_alu_pkg::eew8;
    uop_index = '0;
    vs2_data = '0;
    vs1_data = '0;
    vd_data = '0;
    v0_data = '0;
  endtask

  task automatic drive_random_uop();
    logic [vlen-1:0] r;
    logic [vlen-1:0] m;
    int pick;
    int shape;
    draw(4, r);
    pick = int'(r[3:0]);
    draw(4, r);
    uop_valid = (r[3:0] != 4'd0);
    funct3 = mask_alu_pkg::opmvv;
    if (pick < 15) begin
      funct6 = f6_table[pick];
      vs1 = vs1_table[pick];
    end else begin
      // mostly unknown codes
      draw(15, r);
      if (r[14]) funct3 = r[2:0];
      funct6 = r[8:3];
      vs1 = r[13:9];
    end
    draw(1, r);
    vm = r[0];
    draw(8, r);
    vl = (idx_w + 1)'(int'(r[7:0]) % (vlen + 1));
    draw(idx_w, r);
    vstart = r[idx_w-1:0];
    draw(2, r);
    vd_eew = mask_alu_pkg::eew_e'(2'(int'(r[1:0]) % 3));
    draw(3, r);
    uop_index = r[2:0];
    draw(2, r);
    shape = int'(r[1:0]);
    draw(vlen, vs2_data);
    if (shape == 0) begin
      vs2_data = '0;
    end else if (shape == 1) begin
      draw(vlen, m);
      vs2_data = vs2_data & m;
      draw(vlen, m);
      vs2_data = vs2_data & m;
    end
    draw(vlen, vs1_data);
    draw(vlen, vd_data);
    draw(vlen, v0_data);
  endtask

  initial begin
    int waited;
    lfsr = 32'h66df_247c;
    clear_inputs();
    reset = 1'b1;
    repeat (5) @(posedge clk);
    #1 reset = 1'b0;
    for (int i = 0; i < num_ops; i++) begin
      @(posedge clk);
      #1 drive_random_uop();
    end
    @(posedge clk);
    #1 clear_inputs();
    waited = 0;
    while (pending && waited < drain_limit) begin
      @(posedge clk);
      waited++;
    end
    if (pending) begin
      $display("timeout: last result was never compared");
    end
    $display("checks %0d errors %0d", check_count, error_count);
    if (pending || error_count != 0) begin
      $display("TB FAILED");
    end else begin
      $display("TB PASSED");
    end
    $finish;
  end

endmodule

/* tb.f */
source/mask_alu_pkg.sv
source/mask_src_if.sv
source/mask_operand_prep.sv
source/mask_logic_unit.sv
source/mask_scan_unit.sv
source/mask_count_unit.sv
source/mask_alu_top.sv
tests/mask_alu_checker.sv
tests/tb_mask_alu.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_mask_alu -f tb.f \
  && ./obj_dir/Vtb_mask_alu > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && exit 1
grep -q "TB PASSED" sim.log || exit 1
exit 0
